// File: rtl/kernel_settings.svh
// Build-time sizing for the graph kernel
// Unit count and checksum width set the width of cu_results at the top
// Setup length is counted in ap_clk cycles after control_areset drops
`ifndef KERNEL_SETTINGS_SVH
`define KERNEL_SETTINGS_SVH

// Number of compute units behind one control block
`define NUM_CU 4

// Cycles each unit reports setup after reset
`define CU_SETUP_CYCLES 20

// Checksum width per unit, sums wrap at this width
`define SUM_WIDTH 32

`endif

// File: rtl/graph_kernel_pkg.sv
// Shared types for the graph kernel
// Descriptor packs vertex_base in the upper 32 bits, vertex_count in the low 16
// Control states encode in 3 bits, one code left unused
package graph_kernel_pkg;

    // Block-level control states
    typedef enum logic [2:0] {
        CTRL_RESET = 3'd0,
        CTRL_IDLE  = 3'd1,
        CTRL_SETUP = 3'd2,
        CTRL_READY = 3'd3,
        CTRL_START = 3'd4,
        CTRL_BUSY  = 3'd5,
        CTRL_DONE  = 3'd6
    } kernel_ctrl_state_t;

    // One job for the whole unit array
    typedef struct packed {
        // First vertex index of the job
        logic [31:0] vertex_base;
        // Vertices walked by each unit
        logic [15:0] vertex_count;
    } job_descriptor_t;

endpackage : graph_kernel_pkg

// File: rtl/kernel_ctrl_if.sv
// Block-level control chain, ap_ctrl_hs style
// All signals are plain levels or pulses, no handshake on any of them
`timescale 1ns/1ps

interface kernel_ctrl_if;

    // Host to kernel
    logic start;
    logic continue_job;

    // Kernel to host
    logic ready;
    logic done;
    logic idle;

    // Kernel side of the chain
    modport ctrl (
        input  start,
        input  continue_job,
        output ready,
        output done,
        output idle
    );

    // Host side of the chain
    modport host (
        output start,
        output continue_job,
        input  ready,
        input  done,
        input  idle
    );

endinterface : kernel_ctrl_if

// File: rtl/kernel_control.sv
// Kernel control FSM for the compute unit array
// Inputs take one register stage, outputs two more after the state levels
// ready comes 4 edges after start or continue is sampled, done 3 edges after
// the FSM reaches DONE; desc_valid trails the ready level by 2 cycles
// Host must hold the descriptor stable from write until ready
`timescale 1ns/1ps
`include "kernel_settings.svh"

module kernel_control (
    input  logic                            ap_clk,
    input  logic                            control_areset,
    kernel_ctrl_if.ctrl                     ctrl,
    input  logic [`NUM_CU-1:0]              cu_setup,
    input  logic [`NUM_CU-1:0]              cu_done,
    input  graph_kernel_pkg::job_descriptor_t desc_in,
    output logic                            desc_valid,
    output graph_kernel_pkg::job_descriptor_t desc_out
);

    import graph_kernel_pkg::*;

    // Sampled inputs
    logic              start_q;
    logic              continue_q;
    logic [`NUM_CU-1:0] cu_setup_q;
    logic [`NUM_CU-1:0] cu_done_q;

    // Per-state levels
    logic ready_lvl;
    logic done_lvl;
    logic idle_lvl;
    logic valid_lvl;

    // First output stage
    logic ready_s1;
    logic done_s1;
    logic idle_s1;

    kernel_ctrl_state_t state;
    kernel_ctrl_state_t state_next;

    // --------------------
    // Input registers
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            start_q    <= 1'b0;
            continue_q <= 1'b0;
            // Units count as in setup until told otherwise
            cu_setup_q <= '1;
            cu_done_q  <= '0;
        end else begin
            start_q    <= ctrl.start;
            continue_q <= ctrl.continue_job;
            cu_setup_q <= cu_setup;
            cu_done_q  <= cu_done;
        end
    end

    // --------------------
    // State machine
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            state <= CTRL_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            CTRL_RESET: state_next = CTRL_IDLE;
            CTRL_IDLE:  state_next = CTRL_SETUP;
            // Start only once no unit is still in setup
            CTRL_SETUP: begin
                if (start_q && !(|cu_setup_q)) begin
                    state_next = CTRL_READY;
                end
            end
            CTRL_READY: state_next = CTRL_START;
            CTRL_START: state_next = CTRL_BUSY;
            // Whole array must finish
            CTRL_BUSY: begin
                if (&cu_done_q) begin
                    state_next = CTRL_DONE;
                end
            end
            // Either continue or a fresh start launches the next job
            CTRL_DONE: begin
                if (continue_q || start_q) begin
                    state_next = CTRL_READY;
                end
            end
            default: state_next = CTRL_RESET;
        endcase
    end

    // Levels per state, registered
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ready_lvl <= 1'b0;
            done_lvl  <= 1'b0;
            idle_lvl  <= 1'b1;
            valid_lvl <= 1'b0;
        end else begin
            // READY lasts a single cycle so ready is a one-cycle pulse
            ready_lvl <= (state == CTRL_READY);
            done_lvl  <= (state == CTRL_DONE);
            // Idle outside the active job span
            idle_lvl  <= (state == CTRL_RESET) || (state == CTRL_IDLE) ||
                         (state == CTRL_SETUP) || (state == CTRL_DONE);
            // Descriptor offered from start through busy
            valid_lvl <= (state == CTRL_START) || (state == CTRL_BUSY);
        end
    end

    // --------------------
    // Output stages
    // --------------------

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            ready_s1   <= 1'b0;
            done_s1    <= 1'b0;
            idle_s1    <= 1'b1;
            ctrl.ready <= 1'b0;
            ctrl.done  <= 1'b0;
            ctrl.idle  <= 1'b1;
            desc_valid <= 1'b0;
        end else begin
            ready_s1   <= ready_lvl;
            done_s1    <= done_lvl;
            idle_s1    <= idle_lvl;
            ctrl.ready <= ready_s1;
            ctrl.done  <= done_s1;
            ctrl.idle  <= idle_s1;
            desc_valid <= valid_lvl;
        end
    end

    // Descriptor payload follows the host register
    always_ff @(posedge ap_clk) begin
        desc_out <= desc_in;
    end

endmodule : kernel_control

// File: rtl/vertex_compute_unit.sv
// One vertex compute unit
// Walks vertex_count indices from vertex_base plus CU_INDEX and sums them
// Checksum wraps at SUM_WIDTH bits and holds until the next capture
// Done stays high until desc_valid is seen low
`timescale 1ns/1ps
`include "kernel_settings.svh"

module vertex_compute_unit #(
    parameter int CU_INDEX = 0
) (
    input  logic                            ap_clk,
    input  logic                            control_areset,
    input  logic                            desc_valid,
    input  graph_kernel_pkg::job_descriptor_t desc,
    output logic                            cu_setup,
    output logic                            cu_done,
    output logic [`SUM_WIDTH-1:0]           checksum
);

    localparam int SETUP_W = $clog2(`CU_SETUP_CYCLES + 1);

    logic [SETUP_W-1:0] setup_cnt;
    logic               busy;
    logic [31:0]        vertex_idx;
    logic [15:0]        remaining;

    // Setup countdown
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            setup_cnt <= SETUP_W'(`CU_SETUP_CYCLES);
        end else if (setup_cnt != '0) begin
            setup_cnt <= setup_cnt - 1'b1;
        end
    end

    assign cu_setup = (setup_cnt != '0);

    // Job control
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            busy    <= 1'b0;
            cu_done <= 1'b0;
        end else if (busy) begin
            // Last step reached
            if (remaining == '0) begin
                busy    <= 1'b0;
                cu_done <= 1'b1;
            end
        end else if (cu_done) begin
            // Release once the descriptor is withdrawn
            if (!desc_valid) begin
                cu_done <= 1'b0;
            end
        end else if (desc_valid) begin
            busy <= 1'b1;
        end
    end

    // Range walk and checksum
    always_ff @(posedge ap_clk) begin
        if (!busy && !cu_done && desc_valid) begin
            // Capture, offset by unit index
            vertex_idx <= desc.vertex_base + 32'(CU_INDEX);
            remaining  <= desc.vertex_count;
            checksum   <= '0;
        end else if (busy && remaining != '0) begin
            checksum   <= checksum + `SUM_WIDTH'(vertex_idx);
            vertex_idx <= vertex_idx + 32'd1;
            remaining  <= remaining - 16'd1;
        end
    end

endmodule : vertex_compute_unit

// File: rtl/graph_kernel_top.sv
// Graph kernel top, plain host ports
// Descriptor register loads on job_desc_write, host writes it before start
// cu_results packs unit 0 in the low SUM_WIDTH bits
`timescale 1ns/1ps
`include "kernel_settings.svh"

module graph_kernel_top (
    input  logic                            ap_clk,
    input  logic                            control_areset,
    input  logic                            ap_start,
    input  logic                            ap_continue,
    input  logic                            job_desc_write,
    input  logic [47:0]                     job_desc,
    output logic                            ap_ready,
    output logic                            ap_done,
    output logic                            ap_idle,
    output logic [`NUM_CU*`SUM_WIDTH-1:0]   cu_results
);

    import graph_kernel_pkg::*;

    job_descriptor_t    host_desc;
    job_descriptor_t    desc_bus;
    logic               desc_valid;
    logic [`NUM_CU-1:0] cu_setup;
    logic [`NUM_CU-1:0] cu_done;

    kernel_ctrl_if ctrl_bus ();

    // Host side of the control chain
    assign ctrl_bus.start        = ap_start;
    assign ctrl_bus.continue_job = ap_continue;
    assign ap_ready              = ctrl_bus.ready;
    assign ap_done               = ctrl_bus.done;
    assign ap_idle               = ctrl_bus.idle;

    // Descriptor holding register
    always_ff @(posedge ap_clk) begin
        if (job_desc_write) begin
            host_desc <= job_descriptor_t'(job_desc);
        end
    end

    kernel_control u_kernel_control (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .ctrl           (ctrl_bus),
        .cu_setup       (cu_setup),
        .cu_done        (cu_done),
        .desc_in        (host_desc),
        .desc_valid     (desc_valid),
        .desc_out       (desc_bus)
    );

    // Unit array, each offset by its index
    for (genvar k = 0; k < `NUM_CU; k++) begin : g_cu
        vertex_compute_unit #(
            .CU_INDEX (k)
        ) u_cu (
            .ap_clk         (ap_clk),
            .control_areset (control_areset),
            .desc_valid     (desc_valid),
            .desc           (desc_bus),
            .cu_setup       (cu_setup[k]),
            .cu_done        (cu_done[k]),
            .checksum       (cu_results[k*`SUM_WIDTH +: `SUM_WIDTH])
        );
    end

endmodule : graph_kernel_top

// File: testbench/graph_kernel_top_tb.sv
// Testbench for graph_kernel_top
// Jobs and expected checksums come from testbench/kernel_patterns.mem
// Run from the project root so the pattern path resolves
// Inputs change on the falling edge, outputs are sampled there too
`timescale 1ns/1ps
`include "kernel_settings.svh"

module graph_kernel_top_tb;

    localparam int NUM_JOBS     = 8;
    // Base, count, then one sum per unit
    localparam int COLS         = 2 + `NUM_CU;
    localparam int RESET_CYCLES = 10;
    // Slack per job for control latency and host gaps
    localparam int JOB_MARGIN   = 60;

    logic                          ap_clk;
    logic                          control_areset;
    logic                          ap_start;
    logic                          ap_continue;
    logic                          job_desc_write;
    logic [47:0]                   job_desc;
    logic                          ap_ready;
    logic                          ap_done;
    logic                          ap_idle;
    logic [`NUM_CU*`SUM_WIDTH-1:0] cu_results;

    logic [31:0] patterns [0:NUM_JOBS*COLS-1];
    bit          patterns_loaded = 1'b0;

    int          error_count        = 0;
    int          check_count        = 0;
    int          ready_count        = 0;
    int          done_count         = 0;
    int          cycles_after_reset = 0;
    logic        ready_prev         = 1'b0;
    logic        done_prev          = 1'b0;
    int unsigned rng_state;

    graph_kernel_top u_graph_kernel_top (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .ap_start       (ap_start),
        .ap_continue    (ap_continue),
        .job_desc_write (job_desc_write),
        .job_desc       (job_desc),
        .ap_ready       (ap_ready),
        .ap_done        (ap_done),
        .ap_idle        (ap_idle),
        .cu_results     (cu_results)
    );

    // 10 ns clock
    initial ap_clk = 1'b0;
    always #5 ap_clk = ~ap_clk;

    // --------------------
    // Helpers
    // --------------------

    // LCG step, gap of 0 to 7 cycles from the upper bits
    function automatic int random_gap();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return int'((rng_state >> 16) & 32'h7);
    endfunction

    // Sum of count indices starting at base plus k, wrapped at 32 bits
    function automatic logic [31:0] range_sum(input logic [31:0] base,
                                              input logic [15:0] count,
                                              input int          k);
        logic [63:0] first;
        logic [63:0] n;
        logic [63:0] total;
        first = {32'd0, base + 32'(k)};
        n     = {48'd0, count};
        total = n * first + (n * (n - 64'd1)) / 64'd2;
        return total[31:0];
    endfunction

    task automatic expect_true(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("error: time %0t: %s", $time, what);
            error_count++;
        end
    endtask

    // Called on a falling edge, returns one falling edge later
    task automatic write_descriptor(input int job);
        job_desc       = {patterns[job*COLS], patterns[job*COLS+1][15:0]};
        job_desc_write = 1'b1;
        @(negedge ap_clk);
        job_desc_write = 1'b0;
    endtask

    // --------------------
    // Output monitor
    // --------------------

    // Posedge sampling sees the level held over the previous cycle
    always @(posedge ap_clk) begin
        if (control_areset) begin
            cycles_after_reset = 0;
            ready_prev         = 1'b0;
            done_prev          = 1'b0;
        end else begin
            cycles_after_reset++;
            if (ap_ready && !ready_prev) begin
                ready_count++;
                // First ready must wait out unit setup
                if (ready_count == 1) begin
                    expect_true(cycles_after_reset > `CU_SETUP_CYCLES,
                        $sformatf("ap_ready rose %0d cycles after reset",
                                  cycles_after_reset - 1));
                end
            end
            if (ap_ready) begin
                expect_true(!ready_prev, "ap_ready held high for two cycles");
            end
            if (ap_done && !done_prev) begin
                done_count++;
            end
            ready_prev = ap_ready;
            done_prev  = ap_done;
        end
    end

    // --------------------
    // Stimulus and checks
    // --------------------

    initial begin
        logic [`NUM_CU*`SUM_WIDTH-1:0] held_results;
        logic [`SUM_WIDTH-1:0]         got;
        logic [31:0]                   expected;
        int                            gap;
        int                            row;
        control_areset = 1'b1;
        // Start held high from reset onward
        ap_start       = 1'b1;
        ap_continue    = 1'b0;
        job_desc_write = 1'b0;
        job_desc       = '0;
        rng_state      = 32'd78553;
        $readmemh("testbench/kernel_patterns.mem", patterns);
        if ($isunknown(patterns[NUM_JOBS*COLS-1])) begin
            $display("Pattern file testbench/kernel_patterns.mem is missing or short");
            $display("Test failed");
            $finish;
        end
        patterns_loaded = 1'b1;

        // First descriptor loads while reset is still high
        @(negedge ap_clk);
        write_descriptor(0);
        repeat (RESET_CYCLES - 2) @(negedge ap_clk);
        control_areset = 1'b0;
        expect_true(ap_idle && !ap_ready && !ap_done,
            $sformatf("after reset idle=%b ready=%b done=%b", ap_idle, ap_ready, ap_done));

        for (int j = 0; j < NUM_JOBS; j++) begin
            row = j * COLS;
            if (j > 0) begin
                // Host withholds continue, done must hold
                held_results = cu_results;
                gap = random_gap();
                repeat (gap) begin
                    @(negedge ap_clk);
                    expect_true(ap_done && ap_idle && !ap_ready,
                        $sformatf("job %0d wait: done=%b idle=%b ready=%b",
                                  j - 1, ap_done, ap_idle, ap_ready));
                    expect_true(cu_results == held_results,
                        $sformatf("job %0d wait: cu_results changed", j - 1));
                end
                write_descriptor(j);
                ap_continue = 1'b1;
                @(negedge ap_clk);
                ap_continue = 1'b0;
            end

            // Watchdog bounds both waits
            while (!ap_ready) @(negedge ap_clk);
            ap_start = 1'b0;
            while (!ap_done) @(negedge ap_clk);

            for (int k = 0; k < `NUM_CU; k++) begin
                expected = range_sum(patterns[row], patterns[row+1][15:0], k);
                got      = cu_results[k*`SUM_WIDTH +: `SUM_WIDTH];
                expect_true(patterns[row+2+k] == expected,
                    $sformatf("job %0d unit %0d: file sum %h, expected %h",
                              j, k, patterns[row+2+k], expected));
                expect_true(got == expected,
                    $sformatf("job %0d unit %0d: checksum %h, expected %h",
                              j, k, got, expected));
            end
            expect_true(ready_count == j + 1,
                $sformatf("job %0d: %0d ready pulses so far", j, ready_count));
        end

        // Monitor needs one more edge to count the last done
        @(negedge ap_clk);
        expect_true(ready_count == NUM_JOBS,
            $sformatf("%0d ready pulses for %0d jobs", ready_count, NUM_JOBS));
        expect_true(done_count == NUM_JOBS,
            $sformatf("%0d done rises for %0d jobs", done_count, NUM_JOBS));

        $display("Summary: %0d checks, %0d errors, %0d ready pulses, %0d done rises",
                 check_count, error_count, ready_count, done_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // --------------------
    // Watchdog
    // --------------------

    // Limit grows with total vertex count
    initial begin
        int limit;
        wait (patterns_loaded);
        limit = RESET_CYCLES + `CU_SETUP_CYCLES;
        for (int j = 0; j < NUM_JOBS; j++) begin
            limit += int'(patterns[j*COLS+1][15:0]) + JOB_MARGIN;
        end
        repeat (limit) @(posedge ap_clk);
        $display("Timeout: run did not end within %0d cycles, %0d errors so far",
                 limit, error_count);
        $display("Test failed");
        $finish;
    end

endmodule : graph_kernel_top_tb

// File: src.f
+incdir+rtl
rtl/graph_kernel_pkg.sv
rtl/kernel_ctrl_if.sv
rtl/kernel_control.sv
rtl/vertex_compute_unit.sv
rtl/graph_kernel_top.sv
testbench/graph_kernel_top_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the graph kernel testbench with Verilator
# Must run from the project root so the pattern file path resolves
set -u

cd "$(dirname "$0")" || exit 1

TOP=graph_kernel_top_tb
OBJ_DIR=obj_dir
LOG=sim.log

echo "Building ${TOP}"
verilator --binary --timing --assert -Wno-fatal \
    --top-module "${TOP}" --Mdir "${OBJ_DIR}" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

echo "Running ${TOP}"
"./${OBJ_DIR}/V${TOP}" > "${LOG}" 2>&1
status=$?
cat "${LOG}"
if [ ${status} -ne 0 ]; then
    echo "Simulation exited with status ${status}"
    exit 1
fi

if grep -q "Test completed successfully" "${LOG}"; then
    echo "Simulation passed"
    exit 0
fi

echo "Pass message not found in ${LOG}"
exit 1

// File: testbench/kernel_patterns.mem
// vertex_base vertex_count sum_cu0 sum_cu1 sum_cu2 sum_cu3
// One job per line, all hex, sums wrap at 32 bits
00000000 0010 00000078 00000088 00000098 000000a8
00000100 0005 0000050a 0000050f 00000514 00000519
00001000 0000 00000000 00000000 00000000 00000000
fffffff0 0020 fffffff0 00000010 00000030 00000050
00000001 0001 00000001 00000002 00000003 00000004
12345678 0003 369d036b 369d036e 369d0371 369d0374
00000000 0040 000007e0 00000820 00000860 000008a0
80000000 0002 00000001 00000003 00000005 00000007
